/* Bender.yml */
package:
  name: cart_ddr_bridge

sources:
  - src/mem_map_pkg.sv
  - src/ddr_bus_pkg.sv
  - src/cart_loader.sv
  - src/cart_fetch.sv
  - src/ddr_port_mux.sv
  - src/cart_ddr_bridge.sv
  - target: test
    files:
      - tests/cart_ddr_bridge_chk.sv
      - tests/tb_cart_ddr_bridge.sv

/* project.f */
src/mem_map_pkg.sv
src/ddr_bus_pkg.sv
src/cart_loader.sv
src/cart_fetch.sv
src/ddr_port_mux.sv
src/cart_ddr_bridge.sv
tests/cart_ddr_bridge_chk.sv
tests/tb_cart_ddr_bridge.sv

/* src/cart_ddr_bridge.sv */
// one clock domain; burst count is fixed at one outside this block, ddr_req is single beat
`timescale 1ns/100ps
`default_nettype none

module cart_ddr_bridge (
	input  logic                                clk_sys,
	input  logic                                reset,
	// host download
	input  logic                                dl_active,
	input  logic [7:0]                          dl_index,
	input  logic                                dl_wr,
	input  mem_map_pkg::host_word_t             dl_data,
	output logic                                host_wait,
	// console cartridge bus
	input  logic                                cart_ce_n,
	input  mem_map_pkg::cpu_addr_t              cart_addr,
	output logic [mem_map_pkg::cart_data_w-1:0] cart_q,
	output logic                                cart_wait_n,
	output logic                                console_reset_n,
	// DDR port
	output ddr_bus_pkg::ddr_req_t               ddr_req,
	input  ddr_bus_pkg::ddr_rsp_t               ddr_rsp
);
	import ddr_bus_pkg::*;

	ddr_req_t wr_req;	// loader -> mux
	ddr_req_t rd_req;	// fetcher -> mux
	ddr_rsp_t fetch_rsp;	// port response with fetcher back-pressure
	logic     wr_busy;
	logic     rd_busy;
	logic     loading;

	// ==================================================
	// loader, fetcher, port mux
	// ==================================================
	cart_loader u_cart_loader (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_active       (dl_active),
		.dl_wr           (dl_wr),
		.dl_index        (dl_index),
		.dl_data         (dl_data),
		.ddr_busy        (wr_busy),
		.wr_req          (wr_req),
		.loading         (loading),
		.host_wait       (host_wait),
		.console_reset_n (console_reset_n)
	);

	assign fetch_rsp = '{busy: rd_busy, dout_ready: ddr_rsp.dout_ready, dout: ddr_rsp.dout};

	cart_fetch u_cart_fetch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_ce_n   (cart_ce_n),
		.cart_addr   (cart_addr),
		.rd_req      (rd_req),
		.ddr_rsp     (fetch_rsp),
		.cart_q      (cart_q),
		.cart_wait_n (cart_wait_n)
	);

	ddr_port_mux u_ddr_port_mux (
		.loading (loading),
		.wr_req  (wr_req),
		.rd_req  (rd_req),
		.ddr_rsp (ddr_rsp),
		.ddr_req (ddr_req),
		.wr_busy (wr_busy),
		.rd_busy (rd_busy)
	);

endmodule

`default_nettype wire

/* src/cart_fetch.sv */
// 32-bit cart mode only; the console must keep address and chip enable stable while wait is low
`timescale 1ns/100ps
`default_nettype none

module cart_fetch (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_ce_n,
	input  mem_map_pkg::cpu_addr_t               cart_addr,
	output ddr_bus_pkg::ddr_req_t                rd_req,
	input  ddr_bus_pkg::ddr_rsp_t                ddr_rsp,
	output logic [mem_map_pkg::cart_data_w-1:0]  cart_q,
	output logic                                 cart_wait_n
);
	import mem_map_pkg::*;
	import ddr_bus_pkg::*;

	logic      ce_n_d;	// chip enable, one cycle back
	cpu_addr_t addr_d;	// address, one cycle back
	cpu_addr_t rd_addr;	// address of the read on the port
	logic      rd_pend;
	logic      trigger;
	ddr_word_u rd_word;	// last word back from DDR

	// ==================================================
	// access detect
	// ==================================================
	// falling chip enable, or address moved while enabled
	assign trigger = ~cart_ce_n & (ce_n_d | (cart_addr != addr_d));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ce_n_d      <= 1'b1;
			addr_d      <= '1;	// top of map, never a cart fetch
			rd_pend     <= 1'b0;
			cart_wait_n <= 1'b1;
		end else begin
			ce_n_d <= cart_ce_n;
			addr_d <= cart_addr;

			if (rd_pend && !ddr_rsp.busy)
				rd_pend <= 1'b0;	// taken by the port
			if (trigger)
				rd_pend <= 1'b1;

			// stall the console until the word is back
			if (trigger)
				cart_wait_n <= 1'b0;
			else if (ddr_rsp.dout_ready)
				cart_wait_n <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (trigger)
			rd_addr <= cart_addr;	// frozen for the life of the request
		if (ddr_rsp.dout_ready)
			rd_word <= ddr_rsp.dout;
	end

	// ==================================================
	// DDR read and console data
	// ==================================================
	always_comb begin
		rd_req      = '0;
		rd_req.rd   = rd_pend;
		rd_req.we   = 1'b0;
		rd_req.addr = {ddr_region, rd_addr[cpu_addr_w-1:3]};
		rd_req.be   = '1;	// controller wants all enables on reads
		rd_req.din  = '0;
	end

	// addr bit 2 low -> upper longword
	assign cart_q = rd_word.lw[~cart_addr[2]];

endmodule

`default_nettype wire

/* src/cart_loader.sv */
// host must honour host_wait; a write still pending when the download ends is dropped
`timescale 1ns/100ps
`default_nettype none

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [7:0]              dl_index,
	input  mem_map_pkg::host_word_t dl_data,
	input  logic                    ddr_busy,
	output ddr_bus_pkg::ddr_req_t   wr_req,
	output logic                    loading,
	output logic                    host_wait,
	output logic                    console_reset_n
);
	import mem_map_pkg::*;
	import ddr_bus_pkg::*;

	logic       dl_active_d;	// last cycle's download flag
	logic       dl_start;
	logic       dl_end;
	logic       wr_pend;	// write sitting on the DDR port
	logic       wr_accept;
	cpu_addr_t  load_addr;	// byte address of the next host word
	host_word_t wr_word;	// host word captured at dl_wr
	host_word_t wr_swap;
	logic [1:0] lane_sel;
	ddr_word_u  wr_din;

	// ==================================================
	// download edges and handshake
	// ==================================================
	assign dl_start  = dl_active & ~dl_active_d & (dl_index != '0);	// index 0 is not a cart
	assign dl_end    = ~dl_active & dl_active_d;
	assign wr_accept = wr_pend & ~ddr_busy;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			loading     <= 1'b0;
			host_wait   <= 1'b0;
			wr_pend     <= 1'b0;
			load_addr   <= cart_base;
		end else begin
			dl_active_d <= dl_active;

			if (wr_accept) begin
				load_addr <= load_addr + cpu_addr_w'(2);	// one 16-bit word per write
				wr_pend   <= 1'b0;
				host_wait <= 1'b0;
			end

			// new host word, may land in the same cycle as the last acceptance
			if (loading && dl_wr) begin
				wr_pend   <= 1'b1;
				host_wait <= 1'b1;
			end

			if (dl_start) begin
				load_addr <= cart_base;
				loading   <= 1'b1;
				wr_pend   <= 1'b0;
				host_wait <= 1'b0;
			end

			if (dl_end) begin
				loading   <= 1'b0;
				wr_pend   <= 1'b0;	// nothing left to write into
				host_wait <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (loading && dl_wr)
			wr_word <= dl_data;
	end

	// ==================================================
	// write word build
	// ==================================================
	assign wr_swap  = {wr_word[7:0], wr_word[15:8]};	// host sends bytes swapped
	assign lane_sel = ~load_addr[2:1];	// addr 0 -> lane 3, the top lane

	always_comb begin
		for (int i = 0; i < lane_cnt; i++)
			wr_din.lane[i] = wr_swap;	// same word everywhere, be picks the lane
	end

	always_comb begin
		wr_req      = '0;
		wr_req.rd   = 1'b0;
		wr_req.we   = wr_pend;
		wr_req.addr = {ddr_region, load_addr[cpu_addr_w-1:3]};
		wr_req.be   = be_w'(2'b11) << {lane_sel, 1'b0};	// two bytes of the chosen lane
		wr_req.din  = wr_din;
	end

	assign console_reset_n = ~(reset | dl_active);	// console held for any download

endmodule

`default_nettype wire

/* src/ddr_bus_pkg.sv */
// single-beat DDR port only: no burst count field, one 64-bit word per request
`default_nettype none

package ddr_bus_pkg;
	import mem_map_pkg::*;

	// ==================================================
	// data word geometry
	// ==================================================
	localparam int ddr_data_w = 64;
	localparam int lane_w     = 16;	// one host word
	localparam int lane_cnt   = ddr_data_w / lane_w;
	localparam int lw_cnt     = ddr_data_w / cart_data_w;
	localparam int be_w       = ddr_data_w / 8;	// bit 7 enables the top byte

	// same 64 bits seen as console longwords or as host word lanes
	// lw[1] / lane[3] sit in the upper bits and belong to the lowest byte address
	typedef union packed {
		logic [lw_cnt-1:0][cart_data_w-1:0] lw;	// pick with ~addr[2]
		logic [lane_cnt-1:0][lane_w-1:0]    lane;	// pick with ~addr[2:1]
	} ddr_word_u;

	// ==================================================
	// request and response
	// ==================================================
	typedef struct packed {
		logic                  rd;	// read strobe, held while busy
		logic                  we;	// write strobe, held while busy
		logic [ddr_addr_w-1:0] addr;	// 64-bit word address
		logic [be_w-1:0]       be;	// byte enables, all ones on reads
		ddr_word_u             din;	// write data
	} ddr_req_t;

	typedef struct packed {
		logic      busy;	// request not taken this cycle
		logic      dout_ready;	// one-cycle strobe, dout valid
		ddr_word_u dout;	// read data
	} ddr_rsp_t;

endpackage

`default_nettype wire

/* src/ddr_port_mux.sv */
// purely combinational; the owner only changes when loading toggles
`timescale 1ns/100ps
`default_nettype none

module ddr_port_mux (
	input  logic                  loading,
	input  ddr_bus_pkg::ddr_req_t wr_req,
	input  ddr_bus_pkg::ddr_req_t rd_req,
	input  ddr_bus_pkg::ddr_rsp_t ddr_rsp,
	output ddr_bus_pkg::ddr_req_t ddr_req,
	output logic                  wr_busy,
	output logic                  rd_busy
);

	// ==================================================
	// port owner select
	// ==================================================
	// loader owns the port for the whole download,
	// the fetcher gets it back once loading drops

	always_comb begin
		if (loading) begin
			ddr_req = wr_req;	// loader writes only
			wr_busy = ddr_rsp.busy;
			rd_busy = 1'b1;	// fetcher stalls, no reads reach the port
		end else begin
			ddr_req = rd_req;	// console cart reads
			wr_busy = 1'b1;	// any stray loader write is held off
			rd_busy = ddr_rsp.busy;
		end
	end

	// read data path does not pass through here
	// dout_ready and dout are wired straight to the fetcher at the top level

endmodule

`default_nettype wire

/* src/mem_map_pkg.sv */
// byte addresses are 24 bits; the DDR word address only reaches the fixed 0x30 region
`default_nettype none

package mem_map_pkg;

	// ==================================================
	// bus widths
	// ==================================================
	localparam int cpu_addr_w  = 24;	// console address bus, byte address
	localparam int ddr_addr_w  = 29;	// DDR port word address (64-bit words)
	localparam int host_data_w = 16;	// one download word from the host
	localparam int cart_data_w = 32;	// console cartridge bus in 32-bit mode

	// ==================================================
	// memory map
	// ==================================================
	// cartridge window as the console sees it
	localparam logic [cpu_addr_w-1:0] cart_base = 24'h80_0000;

	// top byte of every DDR word address, console memory lives here
	localparam logic [7:0] ddr_region = 8'h30;

	// word address = ddr_region, byte address bits 23..3
	typedef logic [cpu_addr_w-1:0]  cpu_addr_t;
	typedef logic [host_data_w-1:0] host_word_t;

endpackage

`default_nettype wire

/* tests/cart_ddr_bridge_chk.sv */
// bound into cart_ddr_bridge; expects the host to leave dl_wr low while host_wait is high
`timescale 1ns/100ps
`default_nettype none

module cart_ddr_bridge_chk (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    dl_active,
	input logic                    dl_wr,
	input mem_map_pkg::host_word_t dl_data,
	input logic                    host_wait,
	input logic                    loading,
	input logic                    console_reset_n,
	input ddr_bus_pkg::ddr_req_t   ddr_req,
	input ddr_bus_pkg::ddr_rsp_t   ddr_rsp
);
	import mem_map_pkg::*;
	import ddr_bus_pkg::*;

	int                    fail_cnt = 0;	// watched by the testbench
	host_word_t            last_word;	// newest host word
	host_word_t            swapped;
	logic                  wr_acc;
	logic                  have_prev;	// a write already went out in this download
	logic [ddr_addr_w-1:0] prev_addr;
	logic [be_w-1:0]       prev_be;
	logic                  step_ok;
	logic                  lanes_ok;

	function automatic void flag_fail(input string what);
		fail_cnt++;
		$error("%s", what);
	endfunction

	// ==================================================
	// reference state
	// ==================================================
	assign wr_acc   = ddr_req.we & ~ddr_rsp.busy;
	assign swapped  = {last_word[7:0], last_word[15:8]};
	assign lanes_ok = (ddr_req.din.lane[0] == swapped) && (ddr_req.din.lane[1] == swapped)
		&& (ddr_req.din.lane[2] == swapped) && (ddr_req.din.lane[3] == swapped);
	// 2 bytes up is the next lane down, or lane 3 of the next word after lane 0
	assign step_ok = (prev_be != 8'h03) ?
		(ddr_req.addr == prev_addr && ddr_req.be == (prev_be >> 2)) :
		(ddr_req.addr == prev_addr + 1'b1 && ddr_req.be == 8'hc0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			last_word <= '0;
			have_prev <= 1'b0;
			prev_addr <= '0;
			prev_be   <= '0;
		end else begin
			if (loading && dl_wr)
				last_word <= dl_data;
			if (wr_acc) begin
				prev_addr <= ddr_req.addr;
				prev_be   <= ddr_req.be;
				have_prev <= 1'b1;
			end
			if (!dl_active)
				have_prev <= 1'b0;	// next download starts over
		end
	end

	// ==================================================
	// assertions
	// ==================================================
	a_wr_region: assert property (@(posedge clk_sys) disable iff (reset)
		wr_acc |-> ddr_req.addr[ddr_addr_w-1 -: 8] == ddr_region)
		else flag_fail("accepted write outside the cartridge DDR region");
	a_wr_be: assert property (@(posedge clk_sys) disable iff (reset)
		wr_acc |-> ddr_req.be inside {8'hc0, 8'h30, 8'h0c, 8'h03})
		else flag_fail("accepted write without one whole lane enabled");
	a_wr_data: assert property (@(posedge clk_sys) disable iff (reset)
		wr_acc |-> lanes_ok)
		else flag_fail("accepted write lanes are not the swapped host word");
	a_wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		(loading && dl_wr) |=> host_wait)
		else flag_fail("host_wait did not rise after a host write");
	a_wait_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(host_wait && !wr_acc && dl_active) |=> host_wait)
		else flag_fail("host_wait dropped before the write was taken");
	a_wait_fall: assert property (@(posedge clk_sys) disable iff (reset)
		(wr_acc && !dl_wr) |=> !host_wait)
		else flag_fail("host_wait still high after the write was taken");
	a_addr_step: assert property (@(posedge clk_sys) disable iff (reset)
		(wr_acc && have_prev) |-> step_ok)
		else flag_fail("write address did not advance by 2 bytes");
	a_console_rst: assert property (@(posedge clk_sys) disable iff (reset)
		dl_active |-> !console_reset_n)
		else flag_fail("console left running during a download");
	a_no_read: assert property (@(posedge clk_sys) disable iff (reset)
		loading |-> !ddr_req.rd)
		else flag_fail("DDR read issued while loading");
	a_req_stable: assert property (@(posedge clk_sys) disable iff (reset)
		((ddr_req.rd || ddr_req.we) && ddr_rsp.busy) |=> $stable(ddr_req))
		else flag_fail("DDR request changed while the port was busy");

endmodule

bind cart_ddr_bridge cart_ddr_bridge_chk u_chk (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.dl_active       (dl_active),
	.dl_wr           (dl_wr),
	.dl_data         (dl_data),
	.host_wait       (host_wait),
	.loading         (loading),
	.console_reset_n (console_reset_n),
	.ddr_req         (ddr_req),
	.ddr_rsp         (ddr_rsp)
);

`default_nettype wire

/* tests/tb_cart_ddr_bridge.sv */
// single-beat DDR model with one read in flight; all LFSR stimulus is drawn before reset ends
`timescale 1ns/100ps
`default_nettype none

module tb_cart_ddr_bridge;
	import mem_map_pkg::*;
	import ddr_bus_pkg::*;

	localparam int  n_words    = 16;
	localparam int  n_reads    = n_words / 2 + 1;	// each longword once, then a repeat
	localparam time clk_period = 40;
	localparam time drive_dly  = 2;

	logic                   clk_sys;
	logic                   reset;
	logic                   dl_active;
	logic [7:0]             dl_index;
	logic                   dl_wr;
	host_word_t             dl_data;
	logic                   host_wait;
	logic                   cart_ce_n;
	cpu_addr_t              cart_addr;
	logic [cart_data_w-1:0] cart_q;
	logic                   cart_wait_n;
	logic                   console_reset_n;
	ddr_req_t               ddr_req;
	ddr_rsp_t               ddr_rsp;

	logic [31:0]           lfsr_state = 32'hcda0_2a5e;
	host_word_t            words [n_words];	// download payload
	int                    rd_order [n_reads];
	logic [63:0]           mem [logic [ddr_addr_w-1:0]];	// DDR contents, by word address
	int                    wr_seen = 0;	// writes taken by the model
	int                    rd_left = 0;	// cycles until read data
	logic [ddr_addr_w-1:0] rd_addr;

	cart_ddr_bridge u_cart_ddr_bridge (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_active       (dl_active),
		.dl_index        (dl_index),
		.dl_wr           (dl_wr),
		.dl_data         (dl_data),
		.host_wait       (host_wait),
		.cart_ce_n       (cart_ce_n),
		.cart_addr       (cart_addr),
		.cart_q          (cart_q),
		.cart_wait_n     (cart_wait_n),
		.console_reset_n (console_reset_n),
		.ddr_req         (ddr_req),
		.ddr_rsp         (ddr_rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ==================================================
	// helpers
	// ==================================================
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};	// one step per bit
		end
	endtask

	function automatic host_word_t swap_bytes(input host_word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	// write n of the download lands at cart_base + 2n, lane 3 for the lowest address
	task automatic store_write();
		cpu_addr_t   ba;
		logic [63:0] w;
		ba = cart_base + cpu_addr_t'(2 * wr_seen);
		if (wr_seen >= n_words || ddr_req.addr != {ddr_region, ba[23:3]}
				|| ddr_req.be != (8'hc0 >> (2 * ba[2:1])))
			stop_run($sformatf("Error at %0t: write %0d went to %h with enables %h",
				$time, wr_seen, ddr_req.addr, ddr_req.be));
		if (ddr_req.din.lane[3 - ba[2:1]] != swap_bytes(words[wr_seen]))
			stop_run($sformatf("Error at %0t: write %0d carries %h", $time, wr_seen,
				ddr_req.din));
		w = mem.exists(ddr_req.addr) ? mem[ddr_req.addr] : '0;
		for (int b = 0; b < 8; b++)
			if (ddr_req.be[b])
				w[8*b +: 8] = ddr_req.din[8*b +: 8];
		mem[ddr_req.addr] = w;
		wr_seen++;
	endtask

	task automatic send_word(input host_word_t w);
		repeat (2) @(posedge clk_sys);	// gap between words
		#(drive_dly);
		dl_wr   = 1'b1;
		dl_data = w;
		@(posedge clk_sys);
		#(drive_dly);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		while (host_wait)
			@(negedge clk_sys);
	endtask

	// wait must be low from the cycle after the trigger until the cycle after dout_ready
	task automatic console_read(input int j);
		logic [31:0] exp;
		logic        last_ready;
		logic        released;
		cpu_addr_t   a;
		exp = {swap_bytes(words[2*j]), swap_bytes(words[2*j + 1])};	// upper half first
		a   = cart_base + cpu_addr_t'(4 * j);
		if (!cart_ce_n && cart_addr == a) begin	// same address again, needs a chip enable edge
			@(posedge clk_sys);
			#(drive_dly);
			cart_ce_n = 1'b1;
		end
		@(posedge clk_sys);
		#(drive_dly);
		cart_ce_n  = 1'b0;	// enable held low, a new address alone triggers
		cart_addr  = a;
		@(posedge clk_sys);	// trigger sampled here
		last_ready = 1'b0;
		do begin
			@(negedge clk_sys);
			if (cart_wait_n !== last_ready)
				stop_run($sformatf("Error at %0t: cart_wait_n is %b, expected %b",
					$time, cart_wait_n, last_ready));
			released   = last_ready;
			last_ready = ddr_rsp.dout_ready;
		end while (!released);
		if (cart_q !== exp)
			stop_run($sformatf("Error at %0t: read of %h gave %h, expected %h",
				$time, cart_addr, cart_q, exp));
	endtask

	// ==================================================
	// DDR model
	// ==================================================
	always begin : ddr_model
		logic [31:0] v;
		@(negedge clk_sys);
		if (!reset && ddr_req.we && !ddr_rsp.busy)
			store_write();
		if (!reset && ddr_req.rd && !ddr_rsp.busy) begin
			draw_bits(2, v);
			rd_left = v + 1;	// 1 to 4 cycles
			rd_addr = ddr_req.addr;
		end
		@(posedge clk_sys);
		#(drive_dly);
		ddr_rsp.dout_ready = 1'b0;
		if (rd_left > 0) begin
			rd_left--;
			if (rd_left == 0) begin
				ddr_rsp.dout_ready = 1'b1;
				ddr_rsp.dout       = mem.exists(rd_addr) ? mem[rd_addr] : '0;
			end
		end
		draw_bits(1, v);
		ddr_rsp.busy = v[0];
	end

	always @(u_cart_ddr_bridge.u_chk.fail_cnt)
		if (u_cart_ddr_bridge.u_chk.fail_cnt != 0)
			stop_run("A bound assertion on the DUT failed");

	initial begin
		#((n_words * 12 + n_reads * 16 + 50) * clk_period);
		stop_run("Timeout: the run did not finish in time");
	end

	// ==================================================
	// stimulus
	// ==================================================
	initial begin : stimulus
		logic [31:0] v;
		int          k;
		int          t;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_wr     = 1'b0;
		dl_data   = '0;
		cart_ce_n = 1'b1;
		cart_addr = '0;
		ddr_rsp   = '0;
		for (int i = 0; i < n_words; i++) begin
			draw_bits(host_data_w, v);
			words[i] = v[host_data_w-1:0];
		end
		for (int i = 0; i < n_reads - 1; i++)
			rd_order[i] = i;
		for (int i = n_reads - 2; i > 0; i--) begin	// shuffle
			draw_bits(8, v);
			k           = v % (i + 1);
			t           = rd_order[i];
			rd_order[i] = rd_order[k];
			rd_order[k] = t;
		end
		rd_order[n_reads-1] = rd_order[n_reads-2];	// same address again

		repeat (5) @(posedge clk_sys);
		#(drive_dly);
		reset = 1'b0;
		@(negedge clk_sys);
		if (cart_wait_n !== 1'b1)
			stop_run($sformatf("Error at %0t: cart_wait_n low after reset", $time));

		@(posedge clk_sys);
		#(drive_dly);
		dl_index  = 8'd1;
		dl_active = 1'b1;
		for (int i = 0; i < n_words; i++) begin
			if (i == n_words / 2) begin
				@(posedge clk_sys);
				#(drive_dly);
				cart_ce_n = 1'b0;	// console access mid download, must stay off the port
				cart_addr = cart_base;
			end
			send_word(words[i]);
		end
		@(posedge clk_sys);
		#(drive_dly);
		dl_active = 1'b0;
		@(negedge clk_sys);
		while (!cart_wait_n)
			@(negedge clk_sys);	// held read goes out once loading drops
		repeat (2) @(posedge clk_sys);

		for (int i = 0; i < n_reads; i++)
			console_read(rd_order[i]);
		repeat (2) @(posedge clk_sys);

		if (u_cart_ddr_bridge.u_chk.fail_cnt == 0 && wr_seen == n_words) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_run("Not every download word reached the DDR model");
		end
	end

endmodule

`default_nettype wire
